/* filelist.f */
+incdir+src
src/ara_pkg.sv
src/ara_dispatcher.sv
src/ara_sequencer.sv
src/ara_lane.sv
src/ara_redu.sv
src/ara_top.sv
sim/ara_properties.sv
sim/tb_ara.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the vector accelerator testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ara -f filelist.f -o sim_ara

./obj_dir/sim_ara | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"

/* sim/tb_ara.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the vector accelerator top level
// Register file model, LCG stimulus and response checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_cfg.svh"

module tb_ara;
  import ara_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int NR_ELEMS     = `ARA_NR_LANES * `ARA_ELEMS_PER_LANE;
  // Requests over all tests add up as 2 + 10 + 6 + 12 + 48
  localparam int NUM_REQS     = 78;
  localparam int RESP_TIMEOUT = 32;

  logic      clk_i;
  logic      rst_n_i;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  elem_t       vrf [`ARA_NR_VREGS][NR_ELEMS];
  elem_t       exp_q [$];
  elem_t       exp_val;
  elem_t       last_resp;
  logic [31:0] stim_seed  = 32'd25;
  logic [31:0] bp_seed    = 32'd25;
  logic        bp_mode    = 1'b0;
  logic        ready_next;
  // Set when a handshake times out so later requests are skipped
  logic        aborted    = 1'b0;
  int          errors     = 0;
  int          checks     = 0;
  int          tests      = 0;
  int          req_count  = 0;
  int          resp_count = 0;
  int          test_errors = 0;

  ara_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_seed = lcg_step(stim_seed);
    return {16'h0, stim_seed[31:16]};
  endfunction

  // Applies one instruction to the model and returns the expected response
  function automatic elem_t ref_model(acc_req_t req);
    elem_t sum;
    sum = req.scalar;
    for (int e = 0; e < NR_ELEMS; e++) begin
      case (req.op)
        VOP_VID_ADD: vrf[req.vd][e] = req.scalar + elem_t'(e);
        VOP_VADD:    vrf[req.vd][e] = vrf[req.vs2][e] + vrf[req.vs1][e];
        VOP_VSUB:    vrf[req.vd][e] = vrf[req.vs2][e] - vrf[req.vs1][e];
        VOP_VAND:    vrf[req.vd][e] = vrf[req.vs2][e] & vrf[req.vs1][e];
        VOP_VXOR:    vrf[req.vd][e] = vrf[req.vs2][e] ^ vrf[req.vs1][e];
        default:     sum = sum + vrf[req.vs2][e];
      endcase
    end
    return (req.op == VOP_VREDSUM) ? sum : '0;
  endfunction

  task automatic mark_timeout(string reason);
    $display("%s", reason);
    errors++;
    aborted = 1'b1;
  endtask

  // Sends one request and waits for its response
  task automatic send_req(acc_req_t req);
    int cycles;
    if (!aborted) begin
      exp_q.push_back(ref_model(req));
      req_count++;
      acc_req_i       = req;
      acc_req_valid_i = 1'b1;
      cycles          = 0;
      do begin
        @(posedge clk_i);
        cycles++;
      end while (!acc_req_ready_o && cycles < RESP_TIMEOUT);
      if (!acc_req_ready_o) begin
        mark_timeout("The DUT never accepted the request");
      end else begin
        #10;
        acc_req_valid_i = 1'b0;
        cycles          = 0;
        do begin
          @(posedge clk_i);
          cycles++;
        end while (!(acc_resp_valid_o && acc_resp_ready_i) && cycles < RESP_TIMEOUT);
        if (!(acc_resp_valid_o && acc_resp_ready_i)) begin
          mark_timeout("No response arrived in time");
        end
        #10;
      end
    end
  endtask

  task automatic issue(vop_e op, vreg_idx_t vd, vreg_idx_t vs2, vreg_idx_t vs1, elem_t scalar);
    acc_req_t req;
    req.op     = op;
    req.vd     = vd;
    req.vs1    = vs1;
    req.vs2    = vs2;
    req.scalar = scalar;
    send_req(req);
  endtask

  task automatic send_rand_req();
    acc_req_t    req;
    logic [31:0] hi;
    req.op     = vop_e'(next_rand() % 6);
    req.vd     = vreg_idx_t'(next_rand());
    req.vs1    = vreg_idx_t'(next_rand());
    req.vs2    = vreg_idx_t'(next_rand());
    hi         = next_rand();
    req.scalar = (hi << 16) | next_rand();
    send_req(req);
  endtask

  task automatic end_test(string name);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - test_errors);
    test_errors = errors;
  endtask

  // Response ready toggles randomly while back-pressure is on
  always @(posedge clk_i) begin
    if (bp_mode) bp_seed = lcg_step(bp_seed);
    ready_next = !bp_mode || bp_seed[16];
    #10;
    acc_resp_ready_i = ready_next;
  end

  // Compare every accepted response against the model
  always @(posedge clk_i) begin
    if (rst_n_i && acc_resp_valid_o && acc_resp_ready_i) begin
      resp_count++;
      checks++;
      last_resp = acc_resp_o.result;
      if (exp_q.size() == 0) begin
        $display("The DUT sent a response without an outstanding request");
        errors++;
      end else begin
        exp_val = exp_q.pop_front();
        assert (acc_resp_o.result == exp_val) else begin
          $display("Fail acc_resp_o: got %h, expected %h", acc_resp_o.result, exp_val);
          errors++;
        end
      end
    end
  end

  initial begin
    int        req_start;
    int        resp_start;
    vreg_idx_t vs;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    rst_n_i          = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;

    ////////////////////////////////////////////////////////////////////
    // Idle check and directed programs
    repeat (5) begin
      @(posedge clk_i);
      checks++;
      assert (!acc_resp_valid_o) else begin
        $display("Fail acc_resp_valid_o: got %h, expected %h", acc_resp_valid_o, 1'b0);
        errors++;
      end
      assert (acc_req_ready_o) else begin
        $display("Fail acc_req_ready_o: got %h, expected %h", acc_req_ready_o, 1'b1);
        errors++;
      end
    end
    #10;
    end_test("idle after reset");

    issue(VOP_VID_ADD, 1, 0, 0, 0);
    issue(VOP_VREDSUM, 0, 1, 1, 5);
    checks++;
    assert (last_resp == 32'd125) else begin
      $display("Fail acc_resp_o: got %h, expected %h", last_resp, 32'd125);
      errors++;
    end
    end_test("vid-add and vredsum");

    issue(VOP_VID_ADD, 2, 0, 0, 100);
    issue(VOP_VID_ADD, 3, 0, 0, next_rand());
    for (int i = 0; i < 4; i++) begin
      issue(vop_e'(int'(VOP_VADD) + i), vreg_idx_t'(4 + i), 2, 3, 0);
      issue(VOP_VREDSUM, 0, vreg_idx_t'(4 + i), vreg_idx_t'(4 + i), 0);
    end
    end_test("element-wise operations");

    // Writes still queued in the lanes when the reductions arrive
    issue(VOP_VID_ADD, 0, 0, 0, 32'hffff_fff0);
    issue(VOP_VADD, 5, 0, 1, 0);
    issue(VOP_VXOR, 6, 5, 2, 0);
    issue(VOP_VSUB, 7, 6, 0, 0);
    issue(VOP_VREDSUM, 0, 7, 7, 3);
    issue(VOP_VREDSUM, 0, 5, 5, 0);
    end_test("back-to-back in-flight writes");

    ////////////////////////////////////////////////////////////////////
    // Random programs
    bp_mode    = 1'b1;
    req_start  = req_count;
    resp_start = resp_count;
    repeat (12) send_rand_req();
    bp_mode = 1'b0;
    checks++;
    assert (resp_count - resp_start == req_count - req_start) else begin
      $display("Fail resp_count: got %h, expected %h",
               resp_count - resp_start, req_count - req_start);
      errors++;
    end
    end_test("random back-pressure");

    for (int n = 1; n <= 40; n++) begin
      send_rand_req();
      if (n % 5 == 0) begin
        vs = vreg_idx_t'(next_rand());
        issue(VOP_VREDSUM, 0, vs, vs, next_rand());
      end
    end
    end_test("random program");

    checks++;
    assert (exp_q.size() == 0 && resp_count == req_count) else begin
      $display("Responses and requests do not match at the end of the run");
      errors++;
    end
    $display("Tests %0d, requests %0d, responses %0d, checks %0d, errors %0d",
             tests, req_count, resp_count, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((NUM_REQS * 40 + RESET_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* sim/ara_properties.sv */
//////////////////////////////////////////////////////////////////////
// Handshake checks on the accelerator top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_cfg.svh"

module ara_properties (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               acc_req_ready_o,
  input ara_pkg::acc_resp_t acc_resp_o,
  input logic               acc_resp_valid_o,
  input logic               acc_resp_ready_i
);

  // Limits on the lane count and the vector length
  initial begin
    lanes_pow2: assert ((`ARA_NR_LANES & (`ARA_NR_LANES - 1)) == 0)
      else $error("Lane count is not a power of two");
    elems_per_lane: assert (`ARA_ELEMS_PER_LANE >= 2)
      else $error("Vector length needs at least two elements per lane");
  end

  // Response held until the core takes it
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o))
    else $error("Response changed while the core stalled it");

  // No new request while a response is pending
  req_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o |-> !acc_req_ready_o)
    else $error("Request accepted while a response was pending");

  resp_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(acc_resp_valid_o))
    else $error("Response valid is unknown after reset");

endmodule

bind ara_top ara_properties i_properties (
  .clk_i           (clk_i           ),
  .rst_n_i         (rst_n_i         ),
  .acc_req_ready_o (acc_req_ready_o ),
  .acc_resp_o      (acc_resp_o      ),
  .acc_resp_valid_o(acc_resp_valid_o),
  .acc_resp_ready_i(acc_resp_ready_i)
);

/* src/ara_top.sv */
//////////////////////////////////////////////////////////////////////
// Vector accelerator top level attached to the scalar core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_cfg.svh"

module ara_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  ara_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output ara_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);
  import ara_pkg::*;

  // Dispatcher and sequencer
  lane_req_t     ara_req;
  logic          ara_req_valid;
  logic          ara_req_ready;
  elem_t         red_result;
  logic          red_result_valid;
  // Lanes and reduction unit
  lane_req_t     lane_req;
  logic          lane_req_valid;
  lane_mask_t    lane_req_ready;
  lane_partial_t partial;
  lane_mask_t    partial_valid;
  elem_t         red_scalar;
  logic          red_start;
  elem_t         redu_result;
  logic          redu_result_valid;

  ara_dispatcher i_dispatcher (
    .clk_i             (clk_i           ),
    .rst_n_i           (rst_n_i         ),
    .acc_req_i         (acc_req_i       ),
    .acc_req_valid_i   (acc_req_valid_i ),
    .acc_req_ready_o   (acc_req_ready_o ),
    .acc_resp_o        (acc_resp_o      ),
    .acc_resp_valid_o  (acc_resp_valid_o),
    .acc_resp_ready_i  (acc_resp_ready_i),
    .ara_req_o         (ara_req         ),
    .ara_req_valid_o   (ara_req_valid   ),
    .ara_req_ready_i   (ara_req_ready   ),
    .red_result_i      (red_result      ),
    .red_result_valid_i(red_result_valid)
  );

  ara_sequencer i_sequencer (
    .clk_i             (clk_i            ),
    .rst_n_i           (rst_n_i          ),
    .ara_req_i         (ara_req          ),
    .ara_req_valid_i   (ara_req_valid    ),
    .ara_req_ready_o   (ara_req_ready    ),
    .lane_req_o        (lane_req         ),
    .lane_req_valid_o  (lane_req_valid   ),
    .lane_req_ready_i  (lane_req_ready   ),
    .red_scalar_o      (red_scalar       ),
    .red_start_o       (red_start        ),
    .red_result_i      (redu_result      ),
    .red_result_valid_i(redu_result_valid),
    .red_result_o      (red_result       ),
    .red_result_valid_o(red_result_valid )
  );

  for (genvar l = 0; l < `ARA_NR_LANES; l++) begin : gen_lanes
    ara_lane #(
      .LANE_ID(l)
    ) i_lane (
      .clk_i           (clk_i            ),
      .rst_n_i         (rst_n_i          ),
      .lane_req_i      (lane_req         ),
      .lane_req_valid_i(lane_req_valid   ),
      .lane_req_ready_o(lane_req_ready[l]),
      .partial_o       (partial[l]       ),
      .partial_valid_o (partial_valid[l] )
    );
  end

  ara_redu i_redu (
    .clk_i             (clk_i            ),
    .rst_n_i           (rst_n_i          ),
    .red_scalar_i      (red_scalar       ),
    .red_start_i       (red_start        ),
    .partial_i         (partial          ),
    .partial_valid_i   (partial_valid    ),
    .red_result_o      (redu_result      ),
    .red_result_valid_o(redu_result_valid)
  );

endmodule

/* src/ara_redu.sv */
//////////////////////////////////////////////////////////////////////
// Reduction unit adding the lane partial sums to the scalar
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_cfg.svh"

module ara_redu (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ara_pkg::elem_t         red_scalar_i,
  input  logic                   red_start_i,
  input  ara_pkg::lane_partial_t partial_i,
  input  ara_pkg::lane_mask_t    partial_valid_i,
  output ara_pkg::elem_t         red_result_o,
  output logic                   red_result_valid_o
);
  import ara_pkg::*;

  elem_t         scalar_q;
  lane_mask_t    recv_q;
  lane_mask_t    recv_d;
  lane_partial_t part_q;
  lane_partial_t part_d;
  elem_t         total;

  // Merge this cycle's partials with the stored ones
  always_comb begin
    recv_d = recv_q | partial_valid_i;
    total  = scalar_q;
    for (int l = 0; l < `ARA_NR_LANES; l++) begin
      part_d[l] = partial_valid_i[l] ? partial_i[l] : part_q[l];
      total     = total + part_d[l];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      recv_q             <= '0;
      red_result_valid_o <= 1'b0;
    end else begin
      red_result_valid_o <= &recv_d;
      recv_q             <= (&recv_d) ? '0 : recv_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (red_start_i) begin
      scalar_q <= red_scalar_i;
    end
    part_q <= part_d;
    if (&recv_d) begin
      red_result_o <= total;
    end
  end

endmodule

/* src/ara_lane.sv */
//////////////////////////////////////////////////////////////////////
// Vector lane with instruction queue, register slice and ALU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_cfg.svh"

module ara_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  ara_pkg::lane_req_t lane_req_i,
  input  logic               lane_req_valid_i,
  output logic               lane_req_ready_o,
  output ara_pkg::elem_t     partial_o,
  output logic               partial_valid_o
);
  import ara_pkg::*;

  localparam int unsigned DEPTH     = `ARA_QUEUE_DEPTH;
  localparam int unsigned LAST_ELEM = `ARA_ELEMS_PER_LANE - 1;

  typedef logic [$clog2(DEPTH)-1:0]               qptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0]             qcnt_t;
  typedef logic [$clog2(`ARA_ELEMS_PER_LANE)-1:0] ecnt_t;

  lane_req_t queue_q [DEPTH];
  qptr_t     wr_ptr_q;
  qptr_t     rd_ptr_q;
  qcnt_t     count_q;
  ecnt_t     elem_cnt_q;
  logic      busy;
  logic      push;
  logic      pop;
  lane_req_t insn;

  // Register slice where row r holds element r * lanes + LANE_ID
  elem_t     rf_q [`ARA_NR_VREGS][`ARA_ELEMS_PER_LANE];
  elem_t     opa;
  elem_t     opb;
  elem_t     alu_res;
  elem_t     sum;
  elem_t     acc_q;
  elem_idx_t elem_idx;

  //////////////////////////////////////////////////////////////////////
  // Instruction queue
  assign busy = (count_q != '0);
  assign insn = queue_q[rd_ptr_q];
  assign pop  = busy && (elem_cnt_q == ecnt_t'(LAST_ELEM));
  // A retiring slot frees up in the same cycle
  assign lane_req_ready_o = (count_q != qcnt_t'(DEPTH)) || pop;
  assign push = lane_req_valid_i && lane_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      elem_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == qptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == qptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + qcnt_t'(push) - qcnt_t'(pop);
      if (pop) begin
        elem_cnt_q <= '0;
      end else if (busy) begin
        elem_cnt_q <= elem_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= lane_req_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Execution of one element per cycle
  assign opa      = rf_q[insn.vs2][elem_cnt_q];
  assign opb      = rf_q[insn.vs1][elem_cnt_q];
  assign elem_idx = elem_idx_t'(32'(elem_cnt_q) * `ARA_NR_LANES + LANE_ID);

  always_comb begin
    case (insn.op)
      VOP_VID_ADD: alu_res = insn.scalar + elem_t'(elem_idx);
      VOP_VADD:    alu_res = opa + opb;
      // vd = vs2 - vs1
      VOP_VSUB:    alu_res = opa - opb;
      VOP_VAND:    alu_res = opa & opb;
      VOP_VXOR:    alu_res = opa ^ opb;
      default:     alu_res = '0;
    endcase
  end

  // Running sum of vs2 restarted on the first element
  assign sum = ((elem_cnt_q == '0) ? '0 : acc_q) + opa;

  always_ff @(posedge clk_i) begin
    if (busy && insn.op != VOP_VREDSUM) begin
      rf_q[insn.vd][elem_cnt_q] <= alu_res;
    end
    if (busy) begin
      acc_q <= sum;
    end
    if (pop && insn.op == VOP_VREDSUM) begin
      partial_o <= sum;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      partial_valid_o <= 1'b0;
    end else begin
      partial_valid_o <= pop && (insn.op == VOP_VREDSUM);
    end
  end

endmodule

/* src/ara_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Sequencer broadcasting instructions to the lanes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ara_sequencer (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ara_pkg::lane_req_t  ara_req_i,
  input  logic                ara_req_valid_i,
  output logic                ara_req_ready_o,
  output ara_pkg::lane_req_t  lane_req_o,
  output logic                lane_req_valid_o,
  input  ara_pkg::lane_mask_t lane_req_ready_i,
  output ara_pkg::elem_t      red_scalar_o,
  output logic                red_start_o,
  input  ara_pkg::elem_t      red_result_i,
  input  logic                red_result_valid_i,
  output ara_pkg::elem_t      red_result_o,
  output logic                red_result_valid_o
);
  import ara_pkg::*;

  logic all_ready;
  logic is_red;
  logic red_pending_q;

  assign all_ready = &lane_req_ready_i;
  assign is_red    = (ara_req_i.op == VOP_VREDSUM);

  // A second reduction waits until the first one has returned
  assign ara_req_ready_o = all_ready && !(is_red && red_pending_q);

  // Lanes only see valid when all of them take the instruction together
  assign lane_req_o       = ara_req_i;
  assign lane_req_valid_o = ara_req_valid_i && ara_req_ready_o;

  assign red_start_o  = lane_req_valid_o && is_red;
  assign red_scalar_o = ara_req_i.scalar;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      red_pending_q      <= 1'b0;
      red_result_valid_o <= 1'b0;
    end else begin
      if (red_start_o) begin
        red_pending_q <= 1'b1;
      end else if (red_result_valid_i) begin
        red_pending_q <= 1'b0;
      end
      red_result_valid_o <= red_result_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (red_result_valid_i) begin
      red_result_o <= red_result_i;
    end
  end

endmodule

/* src/ara_dispatcher.sv */
//////////////////////////////////////////////////////////////////////
// Dispatcher between the scalar core and the vector sequencer
// Issues one instruction at a time and returns its response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ara_dispatcher (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ara_pkg::acc_req_t   acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output ara_pkg::acc_resp_t  acc_resp_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i,
  output ara_pkg::lane_req_t  ara_req_o,
  output logic                ara_req_valid_o,
  input  logic                ara_req_ready_i,
  input  ara_pkg::elem_t      red_result_i,
  input  logic                red_result_valid_i
);
  import ara_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RESULT,
    RESPOND
  } disp_state_e;

  disp_state_e state_q;
  disp_state_e state_d;
  lane_req_t   req_q;
  acc_resp_t   resp_q;

  assign acc_req_ready_o  = (state_q == IDLE);
  assign ara_req_valid_o  = (state_q == ISSUE);
  assign acc_resp_valid_o = (state_q == RESPOND);
  assign ara_req_o        = req_q;
  assign acc_resp_o       = resp_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (acc_req_valid_i) state_d = ISSUE;
      ISSUE: begin
        if (ara_req_ready_i) begin
          // Only reductions wait for the lanes
          state_d = (req_q.op == VOP_VREDSUM) ? WAIT_RESULT : RESPOND;
        end
      end
      WAIT_RESULT: if (red_result_valid_i) state_d = RESPOND;
      RESPOND: if (acc_resp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (acc_req_valid_i && acc_req_ready_o) begin
      req_q.op     <= acc_req_i.op;
      req_q.vd     <= acc_req_i.vd;
      req_q.vs1    <= acc_req_i.vs1;
      req_q.vs2    <= acc_req_i.vs2;
      req_q.scalar <= acc_req_i.scalar;
    end
    if (state_q == ISSUE && ara_req_ready_i && req_q.op != VOP_VREDSUM) begin
      resp_q.result <= '0;
    end
    if (state_q == WAIT_RESULT && red_result_valid_i) begin
      resp_q.result <= red_result_i;
    end
  end

endmodule

/* src/ara_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Vector unit types shared by the dispatcher, sequencer and lanes
//////////////////////////////////////////////////////////////////////

`include "ara_cfg.svh"

package ara_pkg;

  // One vector element
  typedef logic [`ARA_ELEM_WIDTH-1:0] elem_t;

  // Vector register number
  typedef logic [$clog2(`ARA_NR_VREGS)-1:0] vreg_idx_t;

  // Element index across the whole vector
  typedef logic [$clog2(`ARA_NR_LANES*`ARA_ELEMS_PER_LANE)-1:0] elem_idx_t;

  // One bit per lane
  typedef logic [`ARA_NR_LANES-1:0] lane_mask_t;

  typedef enum logic [2:0] {
    VOP_VID_ADD,
    VOP_VADD,
    VOP_VSUB,
    VOP_VAND,
    VOP_VXOR,
    VOP_VREDSUM
  } vop_e;

  // Request from the scalar core
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } acc_req_t;

  // Response to the scalar core that is zero unless a reduction
  typedef struct packed {
    elem_t result;
  } acc_resp_t;

  // Instruction broadcast to every lane
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } lane_req_t;

  // Partial sums with one slot per lane
  typedef elem_t [`ARA_NR_LANES-1:0] lane_partial_t;

endpackage

/* src/ara_cfg.svh */
//////////////////////////////////////////////////////////////////////
// Vector unit configuration
// Lane count, register file size and queue depth
//////////////////////////////////////////////////////////////////////

`ifndef ARA_CFG_SVH
`define ARA_CFG_SVH

// Parallel lanes as a power of two
`define ARA_NR_LANES 4

// Elements held by each lane for one register
`define ARA_ELEMS_PER_LANE 4

// Architectural vector registers
`define ARA_NR_VREGS 8

// Width of one element in bits
`define ARA_ELEM_WIDTH 32

// Instructions buffered in front of each lane
`define ARA_QUEUE_DEPTH 2

`endif
